/* src.f */
design/fsab_pkg.sv
design/mem_pkg.sv
design/fsab_intake.sv
design/mem_sequencer.sv
design/mem_bank.sv
design/resp_gather.sv
design/fsab_memory.sv
bench/clk_gen.sv
bench/fsab_memory_properties.sv
bench/tb_fsab_memory.sv

/* run.sh */
#!/bin/bash
# Builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module tb_fsab_memory \
	--Mdir obj_dir -o sim_tb_fsab_memory
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/sim_tb_fsab_memory > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
	exit 1
fi
exit 0

/* bench/tb_fsab_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fsab_memory;
	localparam int CREDITS     = 4;
	localparam int NUM_BANKS   = 4;
	localparam int BANK_WORDS  = 64;
	localparam int TOTAL_WORDS = NUM_BANKS * BANK_WORDS;
	localparam int TIMEOUT     = 2000;  // Cycles per wait

	logic                     clk0_tb, rst0_tb;
	logic                     fsabo_valid;
	fsab_pkg::fsab_req_t      fsabo_req;
	fsab_pkg::fsab_wbeat_t    fsabo_wbeat;
	logic                     fsabo_credit, fsabi_valid;
	fsab_pkg::fsab_resp_hdr_t fsabi_hdr;
	fsab_pkg::data_t          fsabi_data;

	logic [7:0]               model_b [TOTAL_WORDS*8];
	fsab_pkg::data_t          wdata [fsab_pkg::LEN_MAX];
	fsab_pkg::mask_t          wmask [fsab_pkg::LEN_MAX];
	fsab_pkg::fsab_resp_hdr_t exp_hdr_q [$];
	fsab_pkg::data_t          exp_data_q [$];
	int                       sent, back, errors, checks, beat, cur_len, test_err0;
	string                    cur_test;

	clk_gen u_clk (.clk0_tb, .rst0_tb);

	fsab_memory #(.CREDITS(CREDITS), .NUM_BANKS(NUM_BANKS), .BANK_WORDS(BANK_WORDS)) u_dut (
		.clk0_tb, .rst0_tb, .fsabo_valid, .fsabo_req, .fsabo_wbeat,
		.fsabo_credit, .fsabi_valid, .fsabi_hdr, .fsabi_data
	);

	bind fsab_memory fsab_memory_properties u_props (
		.clk0_tb(clk0_tb), .rst0_tb(rst0_tb), .fsabo_credit(fsabo_credit),
		.fsabi_valid(fsabi_valid), .fsabi_hdr(fsabi_hdr)
	);

	function automatic fsab_pkg::data_t model_word(int wa);
		fsab_pkg::data_t d;
		for (int k = 0; k < 8; k++)
			d[8*k +: 8] = model_b[wa*8 + k];
		return d;
	endfunction

	function automatic int word_of(fsab_pkg::addr_t addr, int i);
		return ((int'(addr) >> 3) + i) % TOTAL_WORDS;  // Wraps at top of memory
	endfunction

	task automatic abort_run(string what);
		$display("Run stopped: %s", what);
		$display("TEST FAIL");
		$finish;
	endtask

	task automatic get_credit();
		int t;
		t = 0;
		while (CREDITS - sent + back <= 0) begin
			@(negedge clk0_tb);
			t++;
			if (t > TIMEOUT)
				abort_run("no credit came back in time");
		end
	endtask

	task automatic drive_beat(fsab_pkg::fsab_req_t r, fsab_pkg::fsab_wbeat_t b);
		fsabo_req   = r;
		fsabo_wbeat = b;
		fsabo_valid = 1'b1;
		@(negedge clk0_tb);
		fsabo_valid = 1'b0;
	endtask

	task automatic send_write(fsab_pkg::addr_t addr, int len, int gap_max);
		fsab_pkg::fsab_req_t   r;
		fsab_pkg::fsab_wbeat_t b;
		int                    wa;
		get_credit();
		sent++;
		r = '{mode: fsab_pkg::FSAB_WRITE, did: 4'h0, subdid: 4'h0, addr: addr,
		      len: fsab_pkg::len_t'(len)};
		for (int i = 0; i < len; i++) begin
			b.data = wdata[i];
			b.mask = wmask[i];
			wa = word_of(addr, i);
			for (int k = 0; k < 8; k++)
				if (wmask[i][k])
					model_b[wa*8 + k] = wdata[i][8*k +: 8];
			drive_beat(r, b);
			if (i < len - 1)
				repeat ($urandom_range(gap_max, 0)) @(negedge clk0_tb);
		end
	endtask

	task automatic send_read(fsab_pkg::addr_t addr, int len, int did, int subdid);
		fsab_pkg::fsab_req_t      r;
		fsab_pkg::fsab_resp_hdr_t h;
		get_credit();
		sent++;
		r = '{mode: fsab_pkg::FSAB_READ, did: fsab_pkg::did_t'(did),
		      subdid: fsab_pkg::did_t'(subdid), addr: addr, len: fsab_pkg::len_t'(len)};
		h.did    = r.did;
		h.subdid = r.subdid;
		h.len    = r.len;
		exp_hdr_q.push_back(h);
		for (int i = 0; i < len; i++)
			exp_data_q.push_back(model_word(word_of(addr, i)));  // Contents at send time
		drive_beat(r, '0);
	endtask

	task automatic drain();
		int t;
		t = 0;
		while (sent != back || exp_hdr_q.size() != 0 || beat != 0) begin
			@(negedge clk0_tb);
			t++;
			if (t > TIMEOUT)
				abort_run("requests or responses still outstanding");
		end
	endtask

	task automatic begin_test(string name);
		cur_test  = name;
		test_err0 = errors;
	endtask

	task automatic end_test();
		drain();
		$display("test %-10s done, %0d errors", cur_test, errors - test_err0);
	endtask

	// Checks responses and counts credits on pre-edge values
	always @(posedge clk0_tb) begin
		if (fsabo_credit)
			back++;
		if (fsabi_valid) begin
			if (beat == 0) begin
				if (exp_hdr_q.size() == 0) begin
					$display("Response beat arrived with no read outstanding");
					errors++;
				end else begin
					fsab_pkg::fsab_resp_hdr_t eh;
					eh = exp_hdr_q.pop_front();
					cur_len = int'(eh.len);
					checks++;
					if (fsabi_hdr != eh) begin
						$display("ERR %s hdr expected %h actual %h", cur_test, eh, fsabi_hdr);
						errors++;
					end
				end
			end
			if (exp_data_q.size() != 0) begin
				fsab_pkg::data_t ed;
				ed = exp_data_q.pop_front();
				checks++;
				if (fsabi_data != ed) begin
					$display("ERR %s data expected %h actual %h", cur_test, ed, fsabi_data);
					errors++;
				end
			end
			beat++;
			if (beat >= cur_len)
				beat = 0;
		end else if (beat != 0) begin
			$display("Response burst broke off after %0d beats", beat);
			errors++;
			beat = 0;
		end
	end

	initial begin
		int a;
		int len;
		void'($urandom(32'h3716ef81));
		fsabo_valid = 1'b0;
		fsabo_req   = '0;
		fsabo_wbeat = '0;
		{sent, back, errors, checks, beat, cur_len} = '0;
		cur_test = "reset";
		a = 0;
		while (rst0_tb !== 1'b0) begin
			@(negedge clk0_tb);
			a++;
			if (a > TIMEOUT)
				abort_run("reset never released");
		end

		begin_test("credits");
		repeat (20) @(negedge clk0_tb);
		checks++;
		if (back != 0) begin
			$display("Credit returned before any request was sent");
			errors++;
		end
		for (int w = 0; w < TOTAL_WORDS; w += 8) begin  // Fill also sends CREDITS at once
			for (int i = 0; i < 8; i++) begin
				wdata[i] = {16'hc0de, 8'(w + i), ~8'(w + i), 32'((w + i) * 32'h9e3779b1)};
				wmask[i] = 8'hff;
			end
			send_write(fsab_pkg::addr_t'(w * 8), 8, 0);
		end
		drain();
		repeat (10) @(negedge clk0_tb);
		checks++;
		if (back != sent) begin
			$display("ERR %s credits expected %0d actual %0d", cur_test, sent, back);
			errors++;
		end
		end_test();

		begin_test("readback");
		for (int n = 0; n < 6; n++) begin
			a   = $urandom_range(TOTAL_WORDS * 8 - 1, 0);
			len = $urandom_range(fsab_pkg::LEN_MAX, 1);
			for (int i = 0; i < len; i++) begin
				wdata[i] = {$urandom, $urandom};
				wmask[i] = 8'hff;
			end
			send_write(fsab_pkg::addr_t'(a), len, 2);
			send_read(fsab_pkg::addr_t'(a), len, n, 15 - n);
		end
		end_test();

		begin_test("bytemask");
		for (int n = 0; n < 8; n++) begin
			a   = $urandom_range(TOTAL_WORDS * 8 - 1, 0);
			len = $urandom_range(2, 1);
			for (int i = 0; i < len; i++) begin
				wdata[i] = {$urandom, $urandom};
				wmask[i] = 8'($urandom_range(254, 1));  // Never all or none
			end
			send_write(fsab_pkg::addr_t'(a), len, 1);
			send_read(fsab_pkg::addr_t'(a), len, 3, n);
		end
		end_test();

		begin_test("framing");
		for (int n = 0; n < 10; n++)
			send_read(fsab_pkg::addr_t'($urandom), $urandom_range(fsab_pkg::LEN_MAX, 1),
			          $urandom_range(15, 0), $urandom_range(15, 0));
		end_test();

		begin_test("random");
		for (int n = 0; n < 60; n++) begin
			a   = $urandom_range(65535, 0);  // Whole address range, wraps
			len = $urandom_range(fsab_pkg::LEN_MAX, 1);
			if (n < 4) begin
				a   = 65536 - 8 * (n + 1);  // Runs past the top word
				len = fsab_pkg::LEN_MAX;
			end
			if ((n < 4) ? (n % 2 == 0) : ($urandom_range(1, 0) == 1)) begin
				for (int i = 0; i < len; i++) begin
					wdata[i] = {$urandom, $urandom};
					wmask[i] = 8'($urandom);
				end
				send_write(fsab_pkg::addr_t'(a), len, 3);
			end else begin
				send_read(fsab_pkg::addr_t'(a), len, $urandom_range(15, 0), n % 16);
			end
			repeat ($urandom_range(2, 0)) @(negedge clk0_tb);
		end
		drain();
		repeat (10) @(negedge clk0_tb);
		checks++;
		if (CREDITS - sent + back != CREDITS) begin
			$display("ERR %s credits expected %0d actual %0d", cur_test, CREDITS,
			         CREDITS - sent + back);
			errors++;
		end
		end_test();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* bench/fsab_memory_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module fsab_memory_properties (
	input wire                           clk0_tb,
	input wire                           rst0_tb,
	input wire                           fsabo_credit,
	input wire                           fsabi_valid,
	input wire fsab_pkg::fsab_resp_hdr_t fsabi_hdr
);
	// No response beats while in reset
	a_valid_low_in_reset: assert property (
		@(posedge clk0_tb) rst0_tb |-> !fsabi_valid
	) else $error("fsabi_valid high during reset");

	// Header holds for the whole burst
	a_hdr_stable: assert property (
		@(posedge clk0_tb) disable iff (rst0_tb)
		(fsabi_valid ##1 fsabi_valid) |-> $stable(fsabi_hdr)
	) else $error("fsabi_hdr changed inside a burst");

	a_no_credit_in_reset: assert property (
		@(posedge clk0_tb) rst0_tb |-> !fsabo_credit
	) else $error("fsabo_credit high during reset");

endmodule

`default_nettype wire

/* bench/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
	output logic clk0_tb,
	output logic rst0_tb
);
	initial begin
		clk0_tb = 1'b0;
		forever #2 clk0_tb = ~clk0_tb;  // 4 ns period
	end

	initial begin
		rst0_tb = 1'b1;
		repeat (16) @(posedge clk0_tb);
		@(negedge clk0_tb);
		rst0_tb = 1'b0;
	end

endmodule

`default_nettype wire

/* design/fsab_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module fsab_memory #(
	parameter int CREDITS    = 4,
	parameter int NUM_BANKS  = 4,   // Power of two
	parameter int BANK_WORDS = 64
) (
	input  wire                        clk0_tb,
	input  wire                        rst0_tb,
	input  wire                        fsabo_valid,
	input  wire fsab_pkg::fsab_req_t   fsabo_req,
	input  wire fsab_pkg::fsab_wbeat_t fsabo_wbeat,
	output logic                       fsabo_credit,
	output logic                       fsabi_valid,
	output fsab_pkg::fsab_resp_hdr_t   fsabi_hdr,
	output fsab_pkg::data_t            fsabi_data
);
	fsab_pkg::fsab_req_t      req_head;
	logic                     req_avail, req_pop;
	fsab_pkg::fsab_wbeat_t    wbeat_head;
	logic                     wbeat_pop;
	mem_pkg::mem_cmd_t        bank_cmd [NUM_BANKS];
	mem_pkg::mem_rd_t         bank_rd [NUM_BANKS];
	logic                     hdr_push;
	fsab_pkg::fsab_resp_hdr_t hdr;
	logic                     resp_done;

	fsab_intake #(.CREDITS(CREDITS)) u_intake (
		.clk0_tb, .rst0_tb, .fsabo_valid, .fsabo_req, .fsabo_wbeat,
		.req_pop, .wbeat_pop, .req_head, .req_avail, .wbeat_head
	);

	mem_sequencer #(.CREDITS(CREDITS), .NUM_BANKS(NUM_BANKS)) u_sequencer (
		.clk0_tb, .rst0_tb, .req_head, .req_avail, .wbeat_head,
		.req_pop, .wbeat_pop, .bank_cmd, .hdr_push, .hdr,
		.resp_done, .fsabo_credit
	);

	for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
		mem_bank #(.BANK_WORDS(BANK_WORDS)) u_bank (
			.clk0_tb,
			.cmd (bank_cmd[b]),
			.rd  (bank_rd[b])
		);
	end

	resp_gather #(.CREDITS(CREDITS), .NUM_BANKS(NUM_BANKS)) u_gather (
		.clk0_tb, .rst0_tb, .bank_rd, .hdr_push, .hdr,
		.resp_done, .fsabi_valid, .fsabi_hdr, .fsabi_data
	);

endmodule

`default_nettype wire

/* design/resp_gather.sv */
`timescale 1ns/1ps
`default_nettype none

module resp_gather #(
	parameter int CREDITS   = 4,
	parameter int NUM_BANKS = 4
) (
	input  wire                           clk0_tb,
	input  wire                           rst0_tb,
	input  wire mem_pkg::mem_rd_t         bank_rd [NUM_BANKS],
	input  wire                           hdr_push,
	input  wire fsab_pkg::fsab_resp_hdr_t hdr,
	output logic                          resp_done,
	output logic                          fsabi_valid,
	output fsab_pkg::fsab_resp_hdr_t      fsabi_hdr,
	output fsab_pkg::data_t               fsabi_data
);
	localparam int HQ_DEPTH = CREDITS;
	localparam int DQ_DEPTH = CREDITS * fsab_pkg::LEN_MAX;
	localparam int HQ_PW    = $clog2(HQ_DEPTH);
	localparam int DQ_PW    = $clog2(DQ_DEPTH);
	localparam int HCW      = $clog2(HQ_DEPTH + 1);
	localparam int DCW      = $clog2(DQ_DEPTH + 1);

	fsab_pkg::fsab_resp_hdr_t hdr_mem [HQ_DEPTH];
	fsab_pkg::data_t          data_mem [DQ_DEPTH];
	logic [HQ_PW-1:0]         hq_wr_ptr, hq_rd_ptr;
	logic [DQ_PW-1:0]         dq_wr_ptr, dq_rd_ptr;
	logic [HCW-1:0]           hq_cnt;
	logic [DCW-1:0]           dq_cnt;      // Read words waiting
	fsab_pkg::len_t           burst_left;  // Beats after the current one
	fsab_pkg::fsab_resp_hdr_t head;
	mem_pkg::mem_rd_t         merged;
	logic                     start, emit;

	always_comb begin
		merged = '0;
		for (int b = 0; b < NUM_BANKS; b++) begin
			if (bank_rd[b].valid)
				merged = bank_rd[b];  // One bank returns per cycle at most
		end
	end

	assign head  = hdr_mem[hq_rd_ptr];
	assign start = (burst_left == '0) && !fsabi_valid && (hq_cnt != '0) &&
	               (dq_cnt >= DCW'(head.len));  // Whole burst present
	assign emit  = start || (burst_left != '0);

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			hq_wr_ptr   <= '0;
			hq_rd_ptr   <= '0;
			dq_wr_ptr   <= '0;
			dq_rd_ptr   <= '0;
			hq_cnt      <= '0;
			dq_cnt      <= '0;
			burst_left  <= '0;
			fsabi_valid <= 1'b0;
			resp_done   <= 1'b0;
		end else begin
			hq_cnt <= hq_cnt + HCW'(hdr_push) - HCW'(start);
			dq_cnt <= dq_cnt + DCW'(merged.valid) - DCW'(emit);
			if (hdr_push)
				hq_wr_ptr <= (hq_wr_ptr == HQ_PW'(HQ_DEPTH - 1)) ? '0 : hq_wr_ptr + 1'b1;
			if (start)
				hq_rd_ptr <= (hq_rd_ptr == HQ_PW'(HQ_DEPTH - 1)) ? '0 : hq_rd_ptr + 1'b1;
			if (merged.valid)
				dq_wr_ptr <= (dq_wr_ptr == DQ_PW'(DQ_DEPTH - 1)) ? '0 : dq_wr_ptr + 1'b1;
			if (emit)
				dq_rd_ptr <= (dq_rd_ptr == DQ_PW'(DQ_DEPTH - 1)) ? '0 : dq_rd_ptr + 1'b1;
			if (start)
				burst_left <= head.len - 4'd1;
			else if (burst_left != '0)
				burst_left <= burst_left - 4'd1;
			fsabi_valid <= emit;
			resp_done   <= emit && (start ? head.len == 4'd1 : burst_left == 4'd1);
		end
	end

	always_ff @(posedge clk0_tb) begin
		if (hdr_push)
			hdr_mem[hq_wr_ptr] <= hdr;
		if (merged.valid)
			data_mem[dq_wr_ptr] <= merged.data;
		if (emit)
			fsabi_data <= data_mem[dq_rd_ptr];
		if (start)
			fsabi_hdr <= head;  // Held for the whole burst
	end

endmodule

`default_nettype wire

/* design/mem_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_bank #(
	parameter int BANK_WORDS = 64
) (
	input  wire                    clk0_tb,
	input  wire mem_pkg::mem_cmd_t cmd,
	output mem_pkg::mem_rd_t       rd
);
	localparam int IW = $clog2(BANK_WORDS);

	fsab_pkg::data_t mem [BANK_WORDS];
	logic [IW-1:0]   idx;

	assign idx = cmd.word_addr[IW-1:0];  // Modulo bank size

	always_ff @(posedge clk0_tb) begin
		rd.valid <= cmd.valid && !cmd.write;
		if (cmd.valid && !cmd.write)
			rd.data <= mem[idx];
		if (cmd.valid && cmd.write) begin
			for (int i = 0; i < fsab_pkg::BYTES_PER_WORD; i++) begin
				if (cmd.mask[i])
					mem[idx][8*i +: 8] <= cmd.data[8*i +: 8];
			end
		end
	end

endmodule

`default_nettype wire

/* design/mem_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_sequencer #(
	parameter int CREDITS   = 4,
	parameter int NUM_BANKS = 4
) (
	input  wire                        clk0_tb,
	input  wire                        rst0_tb,
	input  wire fsab_pkg::fsab_req_t   req_head,
	input  wire                        req_avail,
	input  wire fsab_pkg::fsab_wbeat_t wbeat_head,
	output logic                       req_pop,
	output logic                       wbeat_pop,
	output mem_pkg::mem_cmd_t          bank_cmd [NUM_BANKS],
	output logic                       hdr_push,
	output fsab_pkg::fsab_resp_hdr_t   hdr,
	input  wire                        resp_done,
	output logic                       fsabo_credit
);
	localparam int BSEL = $clog2(NUM_BANKS);
	localparam int SW   = $clog2(CREDITS + 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_WR,
		S_RD
	} seq_state_e;

	seq_state_e          state;
	logic                head_vld;    // req_head holds a request not yet started
	logic [SW-1:0]       slots;       // Free response slots
	mem_pkg::word_addr_t waddr;
	fsab_pkg::len_t      words_left;
	logic                start_wr, start_rd, issue, last_word;

	assign start_wr  = (state == S_IDLE) && head_vld &&
	                   req_head.mode == fsab_pkg::FSAB_WRITE;
	assign start_rd  = (state == S_IDLE) && head_vld &&
	                   req_head.mode == fsab_pkg::FSAB_READ && slots != '0;
	assign issue     = (state != S_IDLE);
	assign last_word = issue && (words_left == 4'd1);

	assign req_pop   = (state == S_IDLE) && !head_vld && req_avail;
	assign wbeat_pop = start_wr || (state == S_WR && !last_word);  // Stay a beat ahead
	assign hdr_push  = start_rd;
	assign hdr       = '{did: req_head.did, subdid: req_head.subdid, len: req_head.len};

	always_comb begin
		for (int b = 0; b < NUM_BANKS; b++) begin
			bank_cmd[b].valid     = issue && (waddr[BSEL-1:0] == BSEL'(b));
			bank_cmd[b].write     = (state == S_WR);
			bank_cmd[b].word_addr = waddr >> BSEL;
			bank_cmd[b].data      = wbeat_head.data;
			bank_cmd[b].mask      = wbeat_head.mask;
		end
	end

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			state        <= S_IDLE;
			head_vld     <= 1'b0;
			slots        <= SW'(CREDITS);
			waddr        <= '0;
			words_left   <= '0;
			fsabo_credit <= 1'b0;
		end else begin
			fsabo_credit <= last_word;
			slots        <= slots - SW'(start_rd) + SW'(resp_done);
			if (req_pop)
				head_vld <= 1'b1;
			else if (start_wr || start_rd)
				head_vld <= 1'b0;
			if (start_wr || start_rd) begin
				waddr      <= mem_pkg::word_addr_t'(req_head.addr >> mem_pkg::WORD_SHIFT);
				words_left <= req_head.len;
			end else if (issue) begin
				waddr      <= waddr + 1'b1;  // Wraps past top of memory
				words_left <= words_left - 4'd1;
			end
			case (state)
				S_IDLE: begin
					if (start_wr)
						state <= S_WR;
					else if (start_rd)
						state <= S_RD;
				end
				default: begin
					if (last_word)
						state <= S_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/fsab_intake.sv */
`timescale 1ns/1ps
`default_nettype none

module fsab_intake #(
	parameter int CREDITS = 4
) (
	input  wire                        clk0_tb,
	input  wire                        rst0_tb,
	input  wire                        fsabo_valid,
	input  wire fsab_pkg::fsab_req_t   fsabo_req,
	input  wire fsab_pkg::fsab_wbeat_t fsabo_wbeat,
	input  wire                        req_pop,
	input  wire                        wbeat_pop,
	output fsab_pkg::fsab_req_t        req_head,
	output logic                       req_avail,
	output fsab_pkg::fsab_wbeat_t      wbeat_head
);
	localparam int RQ_DEPTH = CREDITS;
	localparam int DQ_DEPTH = CREDITS * fsab_pkg::LEN_MAX;
	localparam int RQ_PW    = $clog2(RQ_DEPTH);
	localparam int DQ_PW    = $clog2(DQ_DEPTH);
	localparam int RCW      = $clog2(RQ_DEPTH + 1);

	fsab_pkg::fsab_req_t   req_mem [RQ_DEPTH];
	fsab_pkg::fsab_wbeat_t wbeat_mem [DQ_DEPTH];
	logic [RQ_PW-1:0]      req_wr_ptr, req_rd_ptr;
	logic [DQ_PW-1:0]      wbeat_wr_ptr, wbeat_rd_ptr;
	logic [RCW-1:0]        ready_cnt;   // Requests with all their data queued
	fsab_pkg::len_t        beats_left;  // Write beats still to arrive
	logic                  hdr_beat, wbeat_push, req_complete;

	assign hdr_beat     = fsabo_valid && (beats_left == '0);
	assign wbeat_push   = fsabo_valid &&
	                      (beats_left != '0 || fsabo_req.mode == fsab_pkg::FSAB_WRITE);
	assign req_complete = (hdr_beat && (fsabo_req.mode == fsab_pkg::FSAB_READ ||
	                                    fsabo_req.len == 4'd1)) ||
	                      (fsabo_valid && beats_left == 4'd1);
	assign req_avail    = (ready_cnt != '0);

	always_ff @(posedge clk0_tb or posedge rst0_tb) begin
		if (rst0_tb) begin
			beats_left   <= '0;
			ready_cnt    <= '0;
			req_wr_ptr   <= '0;
			req_rd_ptr   <= '0;
			wbeat_wr_ptr <= '0;
			wbeat_rd_ptr <= '0;
		end else begin
			if (hdr_beat && fsabo_req.mode == fsab_pkg::FSAB_WRITE)
				beats_left <= fsabo_req.len - 4'd1;  // First beat carried word 0
			else if (fsabo_valid && beats_left != '0)
				beats_left <= beats_left - 4'd1;
			ready_cnt <= ready_cnt + RCW'(req_complete) - RCW'(req_pop);
			if (hdr_beat)
				req_wr_ptr <= (req_wr_ptr == RQ_PW'(RQ_DEPTH - 1)) ? '0 : req_wr_ptr + 1'b1;
			if (req_pop)
				req_rd_ptr <= (req_rd_ptr == RQ_PW'(RQ_DEPTH - 1)) ? '0 : req_rd_ptr + 1'b1;
			if (wbeat_push)
				wbeat_wr_ptr <= (wbeat_wr_ptr == DQ_PW'(DQ_DEPTH - 1)) ? '0 : wbeat_wr_ptr + 1'b1;
			if (wbeat_pop)
				wbeat_rd_ptr <= (wbeat_rd_ptr == DQ_PW'(DQ_DEPTH - 1)) ? '0 : wbeat_rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk0_tb) begin
		if (hdr_beat)
			req_mem[req_wr_ptr] <= fsabo_req;
		if (wbeat_push)
			wbeat_mem[wbeat_wr_ptr] <= fsabo_wbeat;
		if (req_pop)
			req_head <= req_mem[req_rd_ptr];  // Head shows up a cycle after pop
		if (wbeat_pop)
			wbeat_head <= wbeat_mem[wbeat_rd_ptr];
	end

endmodule

`default_nettype wire

/* design/mem_pkg.sv */
`default_nettype none

package mem_pkg;

	localparam int WORD_SHIFT = $clog2(fsab_pkg::BYTES_PER_WORD);
	localparam int WORD_AW    = $bits(fsab_pkg::addr_t) - WORD_SHIFT;

	typedef logic [WORD_AW-1:0] word_addr_t;

	typedef struct packed {
		logic            valid;
		logic            write;      // 0 = read
		word_addr_t      word_addr;  // Word index inside the bank
		fsab_pkg::data_t data;
		fsab_pkg::mask_t mask;
	} mem_cmd_t;

	typedef struct packed {
		logic            valid;
		fsab_pkg::data_t data;
	} mem_rd_t;

endpackage

`default_nettype wire

/* design/fsab_pkg.sv */
`default_nettype none

package fsab_pkg;

	localparam int LEN_MAX        = 8;   // Longest burst in words
	localparam int BYTES_PER_WORD = 8;

	typedef logic [63:0]               data_t;
	typedef logic [BYTES_PER_WORD-1:0] mask_t;  // 1 = byte is written
	typedef logic [15:0]               addr_t;  // Byte address, low bits ignored
	typedef logic [3:0]                did_t;   // Device or sub-device ID
	typedef logic [3:0]                len_t;   // Words, 1 to LEN_MAX

	typedef enum logic {
		FSAB_READ  = 1'b0,
		FSAB_WRITE = 1'b1
	} fsab_mode_e;

	typedef struct packed {
		fsab_mode_e mode;
		did_t       did;
		did_t       subdid;
		addr_t      addr;
		len_t       len;
	} fsab_req_t;

	typedef struct packed {
		data_t data;
		mask_t mask;
	} fsab_wbeat_t;

	typedef struct packed {
		did_t did;
		did_t subdid;
		len_t len;
	} fsab_resp_hdr_t;

endpackage

`default_nettype wire
